//--- Makefile
# Verilator build and run for the machine CSR unit testbench

VERILATOR ?= verilator
TB_TOP    ?= machine_csr_unit_tb
RTL_TOP   ?= machine_csr_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/machine_csr_unit_tb.sv
// --------------------------------------------------
// Machine CSR unit testbench
// Directed slot-level tests of CSR access, traps,
// double fault, interrupts and the counters
// --------------------------------------------------
`timescale 1ns/1ps

module machine_csr_unit_tb import qv_csr_pkg::*;;

    localparam int          MEPC_BITS    = 24;
    localparam logic [31:0] MIE_MASK     = 32'hFFFF_0080;  // Timer plus lines 0..15
    localparam logic [31:0] MSTATUS_MASK = 32'h0000_0088;  // mie and mpie
    localparam logic [31:0] MEPC_MASK    = 32'h00FF_FFFF;
    localparam logic [31:0] MIP_MASK     = 32'h0003_0000;  // Edge flags only

    logic                 clk;
    logic                 rstn;
    csr_op_e              op;
    csr_addr_t            csr_addr;
    nib_t                 wdata;
    nib_t                 pc;
    logic [15:0]          irq_req;
    logic                 timer_irq;
    nib_t                 rdata;
    nib_idx_t             nibble;
    logic                 redirect;
    logic [MEPC_BITS-1:0] redirect_addr;
    logic                 interrupt_pending;

    integer               seed = 32'h7143_0e4a;
    int                   edge_count;
    int                   slot_index;
    int                   issued = 0;           // Non-idle slots so far
    logic [MEPC_BITS-1:0] slot_target;          // redirect_addr seen on nibble 7
    logic [31:0]          mstatus_exp = 32'h0000_000C;
    logic [31:0]          mie_exp = 32'h0;
    logic [31:0]          mepc_exp = 32'h0;

    machine_csr_unit #(
        .MEPC_BITS (MEPC_BITS)
    ) dut0 (
        .clk               (clk),
        .rstn              (rstn),
        .op                (op),
        .csr_addr          (csr_addr),
        .wdata             (wdata),
        .pc                (pc),
        .irq_req           (irq_req),
        .timer_irq         (timer_irq),
        .rdata             (rdata),
        .nibble            (nibble),
        .redirect          (redirect),
        .redirect_addr     (redirect_addr),
        .interrupt_pending (interrupt_pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Clock edges since reset release
    always @(posedge clk) begin
        if (!rstn) edge_count <= 0;
        else       edge_count <= edge_count + 1;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [MEPC_BITS-1:0] got,
                              input logic [MEPC_BITS-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_nibble(input string name, input nib_idx_t got,
                                input nib_idx_t exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // One 8-clock slot with wdata and pc sent LSB nibble first
    task automatic run_slot(input csr_op_e o, input csr_addr_t a, input logic [31:0] wd,
                            input logic [31:0] pcv, output logic [31:0] rd);
        int   waited;
        logic xfer;
        waited = 0;
        rd     = '0;
        while (nibble != 3'd0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 16) report_failure("timed out waiting for the start of a slot");
        end
        xfer       = o inside {op_ecall, op_ebreak, op_illegal, op_mret, op_irq};
        slot_index = edge_count / 8;
        for (int k = 0; k < 8; k++) begin
            op       = o;
            csr_addr = a;
            wdata    = wd[4*k +: 4];
            pc       = pcv[4*k +: 4];
            #5;   // Sample late in the clock period
            check_nibble("nibble", nibble, nib_idx_t'(k));
            rd[4*k +: 4] = rdata;
            check_bit("redirect", redirect, xfer && (k == 7));
            if (k == 7) slot_target = redirect_addr;
            @(posedge clk);
            #1;
        end
        op       = op_none;
        csr_addr = '0;
        wdata    = '0;
        pc       = '0;
        if (o != op_none) issued++;
    endtask

    task automatic read_csr(input csr_addr_t a, output logic [31:0] rd);
        run_slot(op_csrrs, a, 32'h0, 32'h0, rd);
    endtask

    // Old value comes back and the shadow follows the write rule
    task automatic csr_op_check(input csr_op_e o, input csr_addr_t a, input string name,
                                input logic [31:0] wd, input logic [31:0] mask,
                                input logic [31:0] fixed, inout logic [31:0] shadow);
        logic [31:0] rd;
        logic [31:0] raw;
        run_slot(o, a, wd, 32'h0, rd);
        check_word(name, rd, shadow);
        case (o)
            op_csrrs: raw = shadow | wd;
            op_csrrc: raw = shadow & ~wd;
            default:  raw = wd;
        endcase
        shadow = (raw & mask) | fixed;
    endtask

    task automatic exercise_csr(input csr_addr_t a, input string name,
                                input logic [31:0] mask, input logic [31:0] fixed,
                                inout logic [31:0] shadow);
        logic [31:0] rd;
        logic [31:0] wd;
        wd = $random(seed);
        csr_op_check(op_csrrw, a, name, wd, mask, fixed, shadow);
        wd = $random(seed);
        csr_op_check(op_csrrs, a, name, wd, mask, fixed, shadow);
        wd = $random(seed);
        csr_op_check(op_csrrc, a, name, wd, mask, fixed, shadow);
        read_csr(a, rd);
        check_word(name, rd, shadow);
    endtask

    // mpie takes mie while mie and mte drop
    function automatic logic [31:0] status_after_entry(input logic [31:0] s);
        return {24'h0, s[3], 7'b0};
    endfunction

    function automatic logic [31:0] status_after_mret(input logic [31:0] s);
        return {24'h0, s[7], 3'b000, s[7], 1'b1, 2'b00};
    endfunction

    task automatic trap_and_return(input csr_op_e o, input logic [31:0] cause,
                                   input logic [MEPC_BITS-1:0] target);
        logic [31:0] rd;
        logic [31:0] pcv;
        pcv = $random(seed);
        run_slot(o, 12'h000, 32'h0, pcv, rd);
        check_addr("redirect_addr", slot_target, target);
        mstatus_exp = status_after_entry(mstatus_exp);
        mepc_exp    = pcv & MEPC_MASK;
        read_csr(CSR_MCAUSE, rd);
        check_word("mcause", rd, cause);
        read_csr(CSR_MEPC, rd);
        check_word("mepc", rd, mepc_exp);
        read_csr(CSR_MSTATUS, rd);
        check_word("mstatus", rd, mstatus_exp);
        run_slot(op_mret, 12'h000, 32'h0, 32'h0, rd);
        check_addr("redirect_addr", slot_target, mepc_exp[MEPC_BITS-1:0]);
        mstatus_exp = status_after_mret(mstatus_exp);
        read_csr(CSR_MSTATUS, rd);
        check_word("mstatus", rd, mstatus_exp);
    endtask

    task automatic test_reset_values();
        logic [31:0] rd;
        read_csr(CSR_MSTATUS, rd);
        check_word("mstatus", rd, 32'h0000_000C);
        read_csr(CSR_MISA, rd);
        check_word("misa", rd, MISA_VALUE);
        read_csr(CSR_MIMPID, rd);
        check_word("mimpid", rd, 32'd3);
        read_csr(CSR_MIE, rd);
        check_word("mie", rd, 32'h0);
        read_csr(CSR_MIP, rd);
        check_word("mip", rd, 32'h0);
        read_csr(CSR_MCAUSE, rd);
        check_word("mcause", rd, 32'h0);
    endtask

    task automatic test_csr_access();
        logic [31:0] rd;
        exercise_csr(CSR_MIE, "mie", MIE_MASK, 32'h0, mie_exp);
        exercise_csr(CSR_MSTATUS, "mstatus", MSTATUS_MASK, 32'h4, mstatus_exp);
        exercise_csr(CSR_MEPC, "mepc", MEPC_MASK, 32'h0, mepc_exp);
        csr_op_check(op_csrrw, CSR_MIE, "mie", 32'h0, MIE_MASK, 32'h0, mie_exp);
        csr_op_check(op_csrrw, CSR_MSTATUS, "mstatus", 32'h8, MSTATUS_MASK, 32'h4,
                     mstatus_exp);
        read_csr(CSR_MSTATUS, rd);
        check_word("mstatus", rd, 32'h0000_000C);
    endtask

    task automatic test_traps();
        trap_and_return(op_ecall, {27'b0, CAUSE_ECALL}, VEC_TRAP[MEPC_BITS-1:0]);
        trap_and_return(op_ebreak, {27'b0, CAUSE_EBREAK}, VEC_TRAP[MEPC_BITS-1:0]);
        trap_and_return(op_illegal, {27'b0, CAUSE_ILLEGAL}, VEC_TRAP[MEPC_BITS-1:0]);
    endtask

    task automatic test_double_fault();
        logic [31:0] rd;
        logic [31:0] pcv;
        csr_op_check(op_csrrw, CSR_MIE, "mie", MIE_MASK, MIE_MASK, 32'h0, mie_exp);
        pcv = $random(seed);
        run_slot(op_ecall, 12'h000, 32'h0, pcv, rd);
        check_addr("redirect_addr", slot_target, VEC_TRAP[MEPC_BITS-1:0]);
        pcv = $random(seed);   // Second trap while mte is clear
        run_slot(op_ebreak, 12'h000, 32'h0, pcv, rd);
        check_addr("redirect_addr", slot_target, VEC_RESET[MEPC_BITS-1:0]);
        mstatus_exp = 32'h0000_000C;
        mie_exp     = 32'h0;
        mepc_exp    = pcv & MEPC_MASK;
        read_csr(CSR_MSTATUS, rd);
        check_word("mstatus", rd, mstatus_exp);
        read_csr(CSR_MIE, rd);
        check_word("mie", rd, mie_exp);
        read_csr(CSR_MCAUSE, rd);
        check_word("mcause", rd, {27'b0, CAUSE_EBREAK});
        read_csr(CSR_MEPC, rd);
        check_word("mepc", rd, mepc_exp);
    endtask

    task automatic test_interrupts();
        logic [31:0] rd;
        logic [31:0] mip_exp;
        csr_op_check(op_csrrc, CSR_MSTATUS, "mstatus", 32'h8, MSTATUS_MASK, 32'h4,
                     mstatus_exp);
        irq_req[5] = 1'b1;   // Level line
        csr_op_check(op_csrrw, CSR_MIE, "mie", 32'h0020_0000, MIE_MASK, 32'h0, mie_exp);
        check_bit("interrupt_pending", interrupt_pending, 1'b0);
        csr_op_check(op_csrrs, CSR_MSTATUS, "mstatus", 32'h8, MSTATUS_MASK, 32'h4,
                     mstatus_exp);
        check_bit("interrupt_pending", interrupt_pending, 1'b1);
        read_csr(CSR_MIP, rd);
        check_word("mip", rd, 32'h0020_0000);
        trap_and_return(op_irq, {1'b1, 26'b0, CAUSE_LINE_BASE + 5'd5},
                        VEC_IRQ[MEPC_BITS-1:0]);
        check_bit("interrupt_pending", interrupt_pending, 1'b1);
        // Timer beats line 5
        timer_irq = 1'b1;
        csr_op_check(op_csrrs, CSR_MIE, "mie", 32'h0000_0080, MIE_MASK, 32'h0, mie_exp);
        trap_and_return(op_irq, {1'b1, 26'b0, CAUSE_TIMER}, VEC_IRQ[MEPC_BITS-1:0]);
        timer_irq = 1'b0;
        irq_req   = '0;
        csr_op_check(op_csrrw, CSR_MIE, "mie", 32'h0001_0000, MIE_MASK, 32'h0, mie_exp);
        check_bit("interrupt_pending", interrupt_pending, 1'b0);
        irq_req[0] = 1'b1;   // One-slot pulse on the edge line
        run_slot(op_none, 12'h000, 32'h0, 32'h0, rd);
        irq_req[0] = 1'b0;
        run_slot(op_none, 12'h000, 32'h0, 32'h0, rd);
        check_bit("interrupt_pending", interrupt_pending, 1'b1);
        mip_exp = 32'h0001_0000;
        csr_op_check(op_csrrc, CSR_MIP, "mip", 32'h0001_0000, MIP_MASK, 32'h0, mip_exp);
        check_bit("interrupt_pending", interrupt_pending, 1'b0);
        read_csr(CSR_MIP, rd);
        check_word("mip", rd, mip_exp);
        csr_op_check(op_csrrw, CSR_MIE, "mie", 32'h0, MIE_MASK, 32'h0, mie_exp);
    endtask

    task automatic test_counters();
        logic [31:0] rd;
        logic [31:0] exp;
        read_csr(CSR_CYCLE, rd);
        check_word("cycle", rd, 32'(slot_index));
        repeat (3) run_slot(op_none, 12'h000, 32'h0, 32'h0, rd);
        exp = 32'(issued);
        read_csr(CSR_INSTRET, rd);
        check_word("instret", rd, exp);
        read_csr(CSR_CYCLE, rd);
        check_word("cycle", rd, 32'(slot_index));
        exp = 32'(issued);
        read_csr(CSR_INSTRET, rd);
        check_word("instret", rd, exp);
    endtask

    initial begin
        rstn      = 1'b0;
        op        = op_none;
        csr_addr  = '0;
        wdata     = '0;
        pc        = '0;
        irq_req   = '0;
        timer_irq = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_values();
        test_csr_access();
        test_traps();
        test_double_fault();
        test_interrupts();
        test_counters();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- hw/csr_read_mux.sv
// --------------------------------------------------
// CSR read mux
// Picks the read nibble of the addressed CSR for
// the current nibble index, unknown CSRs read 0
// --------------------------------------------------
`timescale 1ns/1ps

module csr_read_mux import qv_csr_pkg::*; (
    input  nib_idx_t  nibble,
    input  csr_addr_t csr_addr,
    input  nib_t      mstatus_nib,
    input  nib_t      mie_nib,
    input  nib_t      mip_nib,
    input  nib_t      mcause_nib,
    input  nib_t      mepc_nib,
    input  nib_t      cycle_nib,
    input  nib_t      instret_nib,
    output nib_t      rdata
);

    logic [4:0] bit_lo;   // LSB position of the current nibble

    assign bit_lo = {nibble, 2'b00};

    // Register blocks already present their nibble for this index;
    // constants are sliced here
    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: rdata = mstatus_nib;
            CSR_MISA:    rdata = MISA_VALUE[bit_lo +: 4];
            CSR_MIE:     rdata = mie_nib;
            CSR_MEPC:    rdata = mepc_nib;
            CSR_MCAUSE:  rdata = mcause_nib;
            CSR_MIP:     rdata = mip_nib;
            CSR_CYCLE:   rdata = cycle_nib;
            CSR_INSTRET: rdata = instret_nib;
            CSR_MIMPID:  rdata = MIMPID_VALUE[bit_lo +: 4];
            default:     rdata = 4'b0000;
        endcase
    end

endmodule

//--- hw/csr_timebase.sv
// --------------------------------------------------
// CSR timebase
// Free-running slot nibble counter plus the
// nibble-serial cycle and instret counters
// --------------------------------------------------
`timescale 1ns/1ps

module csr_timebase import qv_csr_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  csr_op_e  op,
    output nib_idx_t nibble,
    output logic     slot_last,
    output nib_t     cycle_nib,
    output nib_t     instret_nib
);

    // Index 0 is cycle, index 1 is instret
    logic [31:0] cnt_q   [2];
    logic [1:0]  carry_q;
    logic [1:0]  inc;
    logic [1:0]  cin;
    logic [4:0]  sum     [2];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            nibble <= '0;
        end else begin
            nibble <= nibble + 3'd1;   // Wraps 7 -> 0
        end
    end

    assign slot_last = (nibble == 3'd7);

    // Cycle bumps every slot, instret only for real work
    assign inc[0] = 1'b1;
    assign inc[1] = (op != op_none);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cin[i] = (nibble == 3'd0) ? inc[i] : carry_q[i];
            sum[i] = {1'b0, cnt_q[i][3:0]} + {4'b0000, cin[i]};
        end
    end

    // Each counter rotates one nibble per clock, carry ripples
    // across the slot and is dropped after nibble 7
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2; i++) begin
                cnt_q[i] <= '0;
            end
            carry_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                cnt_q[i]   <= {sum[i][3:0], cnt_q[i][31:4]};
                carry_q[i] <= sum[i][4];
            end
        end
    end

    // Old value, increment lands at the clock edge
    assign cycle_nib   = cnt_q[0][3:0];
    assign instret_nib = cnt_q[1][3:0];

    // Slots stay exactly 8 clocks long
    assert property (@(posedge clk) disable iff (!rstn)
        (nibble == 3'd7) |=> (nibble == 3'd0))
        else $error("nibble index did not wrap from 7 to 0");

endmodule

//--- hw/irq_controller.sv
// --------------------------------------------------
// Interrupt controller
// mie enables, mip edge flags, edge capture on
// lines 0/1 and fixed-priority cause encoding
// --------------------------------------------------
`timescale 1ns/1ps

module irq_controller import qv_csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  nib_idx_t    nibble,
    input  csr_op_e     op,
    input  csr_addr_t   csr_addr,
    input  nib_t        wdata,
    input  logic [15:0] irq_req,
    input  logic        timer_irq,
    input  logic        mstatus_mie,
    input  logic        double_fault,
    output nib_t        mie_nib,
    output nib_t        mip_nib,
    output logic [4:0]  irq_cause,
    output logic        interrupt_pending
);

    logic        timer_en;      // mie bit 7
    logic [15:0] line_en;       // mie bits 16..31
    logic [1:0]  edge_flags;    // Latched rises, mip bits 16 and 17
    logic [1:0]  last_req;
    logic [1:0]  rise;
    logic [15:0] line_req;
    logic [15:0] line_mask;
    logic        timer_mask;
    nib_t        mie_new;
    nib_t        mip_new;

    assign line_req   = {irq_req[15:2], edge_flags};   // Lines 2..15 are level
    assign line_mask  = line_req & line_en;
    assign timer_mask = timer_irq & timer_en;
    assign rise       = irq_req[1:0] & ~last_req;

    assign interrupt_pending = mstatus_mie && (timer_mask || (|line_mask));

    always_comb begin
        case (nibble)
            3'd1:    mie_nib = {timer_en, 3'b000};
            3'd4:    mie_nib = line_en[3:0];
            3'd5:    mie_nib = line_en[7:4];
            3'd6:    mie_nib = line_en[11:8];
            3'd7:    mie_nib = line_en[15:12];
            default: mie_nib = 4'b0000;
        endcase
    end

    always_comb begin
        case (nibble)
            3'd1:    mip_nib = {timer_irq, 3'b000};
            3'd4:    mip_nib = line_req[3:0];
            3'd5:    mip_nib = line_req[7:4];
            3'd6:    mip_nib = line_req[11:8];
            3'd7:    mip_nib = line_req[15:12];
            default: mip_nib = 4'b0000;
        endcase
    end

    assign mie_new = csr_apply(op, mie_nib, wdata);
    assign mip_new = csr_apply(op, mip_nib, wdata);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            timer_en <= 1'b0;
            line_en  <= '0;
        end else if (double_fault) begin
            timer_en <= 1'b0;
            line_en  <= '0;
        end else if (csr_addr == CSR_MIE) begin
            case (nibble)
                3'd1:    timer_en       <= mie_new[3];
                3'd4:    line_en[3:0]   <= mie_new;
                3'd5:    line_en[7:4]   <= mie_new;
                3'd6:    line_en[11:8]  <= mie_new;
                3'd7:    line_en[15:12] <= mie_new;
                default: ;
            endcase
        end
    end

    // Sample on nibble 5, after any mip write on nibble 4
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            edge_flags <= '0;
            last_req   <= '0;
        end else begin
            if (nibble == 3'd5) last_req <= irq_req[1:0];
            if (double_fault) begin
                edge_flags <= '0;
            end else if (nibble == 3'd4 && csr_addr == CSR_MIP) begin
                edge_flags <= mip_new[1:0];
            end else if (nibble == 3'd5) begin
                edge_flags <= edge_flags | rise;
            end
        end
    end

    // Timer wins, then the lowest enabled line
    always_comb begin
        irq_cause = CAUSE_LINE_BASE;
        for (int i = 15; i >= 0; i--) begin
            if (line_mask[i]) irq_cause = CAUSE_LINE_BASE + 5'(i);
        end
        if (timer_mask) irq_cause = CAUSE_TIMER;
    end

    assert property (@(posedge clk) disable iff (!rstn)
        interrupt_pending |->
            ((irq_cause == CAUSE_TIMER) ? timer_mask : line_mask[irq_cause[3:0]]))
        else $error("pending interrupt with no matching enabled source");

endmodule

//--- hw/machine_csr_unit.sv
// --------------------------------------------------
// Machine CSR unit
// Top level of the machine-mode trap and CSR block,
// driven one 8-clock slot at a time by a decoder
// --------------------------------------------------
`timescale 1ns/1ps

module machine_csr_unit import qv_csr_pkg::*; #(
    parameter int MEPC_BITS = 24
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_op_e              op,
    input  csr_addr_t            csr_addr,
    input  nib_t                 wdata,       // Nibble k of source during nibble k
    input  nib_t                 pc,
    input  logic [15:0]          irq_req,
    input  logic                 timer_irq,
    output nib_t                 rdata,
    output nib_idx_t             nibble,
    output logic                 redirect,
    output logic [MEPC_BITS-1:0] redirect_addr,
    output logic                 interrupt_pending
);

    logic       slot_last;
    nib_t       cycle_nib;
    nib_t       instret_nib;
    logic       mstatus_mie;
    nib_t       mstatus_nib;
    logic       double_fault;
    nib_t       mcause_nib;
    nib_t       mepc_nib;
    nib_t       mie_nib;
    nib_t       mip_nib;
    logic [4:0] irq_cause;

    csr_timebase u_timebase (
        .clk         (clk),
        .rstn        (rstn),
        .op          (op),
        .nibble      (nibble),
        .slot_last   (slot_last),
        .cycle_nib   (cycle_nib),
        .instret_nib (instret_nib)
    );

    trap_status #(
        .MEPC_BITS (MEPC_BITS)
    ) u_trap (
        .clk           (clk),
        .rstn          (rstn),
        .nibble        (nibble),
        .slot_last     (slot_last),
        .op            (op),
        .csr_addr      (csr_addr),
        .wdata         (wdata),
        .pc            (pc),
        .irq_cause     (irq_cause),
        .mstatus_mie   (mstatus_mie),
        .mstatus_nib   (mstatus_nib),
        .double_fault  (double_fault),
        .mcause_nib    (mcause_nib),
        .mepc_nib      (mepc_nib),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    irq_controller u_irq (
        .clk               (clk),
        .rstn              (rstn),
        .nibble            (nibble),
        .op                (op),
        .csr_addr          (csr_addr),
        .wdata             (wdata),
        .irq_req           (irq_req),
        .timer_irq         (timer_irq),
        .mstatus_mie       (mstatus_mie),
        .double_fault      (double_fault),
        .mie_nib           (mie_nib),
        .mip_nib           (mip_nib),
        .irq_cause         (irq_cause),
        .interrupt_pending (interrupt_pending)
    );

    csr_read_mux u_rmux (
        .nibble      (nibble),
        .csr_addr    (csr_addr),
        .mstatus_nib (mstatus_nib),
        .mie_nib     (mie_nib),
        .mip_nib     (mip_nib),
        .mcause_nib  (mcause_nib),
        .mepc_nib    (mepc_nib),
        .cycle_nib   (cycle_nib),
        .instret_nib (instret_nib),
        .rdata       (rdata)
    );

endmodule

//--- hw/qv_csr_pkg.sv
// --------------------------------------------------
// Machine CSR unit package
// Slot opcodes, nibble types, CSR address map,
// trap cause codes and redirect vectors
// --------------------------------------------------
package qv_csr_pkg;

    // One opcode per 8-clock slot, held by the decoder
    typedef enum logic [3:0] {
        op_none,
        op_csrrw,
        op_csrrs,
        op_csrrc,
        op_ecall,
        op_ebreak,
        op_illegal,
        op_mret,
        op_irq
    } csr_op_e;

    typedef logic [3:0]  nib_t;
    typedef logic [2:0]  nib_idx_t;   // Nibble 0 is the LSB nibble
    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MISA    = 12'h301;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MIP     = 12'h344;
    localparam csr_addr_t CSR_CYCLE   = 12'hC00;
    localparam csr_addr_t CSR_INSTRET = 12'hC02;
    localparam csr_addr_t CSR_MIMPID  = 12'hF13;

    localparam logic [31:0] MISA_VALUE   = 32'h4000_0014;  // RV32EC
    localparam logic [31:0] MIMPID_VALUE = 32'd3;

    localparam logic [4:0] CAUSE_ECALL     = 5'd11;
    localparam logic [4:0] CAUSE_EBREAK    = 5'd3;
    localparam logic [4:0] CAUSE_ILLEGAL   = 5'd2;
    localparam logic [4:0] CAUSE_TIMER     = 5'd7;
    localparam logic [4:0] CAUSE_LINE_BASE = 5'd16;  // Line n gives 16 + n

    localparam logic [31:0] VEC_RESET = 32'h0;
    localparam logic [31:0] VEC_TRAP  = 32'h4;
    localparam logic [31:0] VEC_IRQ   = 32'h8;

    // Write, set or clear of one nibble; other ops keep the old value
    function automatic nib_t csr_apply(csr_op_e op, nib_t old_v, nib_t wd);
        case (op)
            op_csrrw: return wd;
            op_csrrs: return old_v | wd;
            op_csrrc: return old_v & ~wd;
            default:  return old_v;
        endcase
    endfunction

endpackage

//--- hw/trap_status.sv
// --------------------------------------------------
// Trap status
// mstatus with trap enable and double-fault recovery,
// mcause, serial mepc and the redirect pulse/target
// --------------------------------------------------
`timescale 1ns/1ps

module trap_status import qv_csr_pkg::*; #(
    parameter int MEPC_BITS = 24
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  nib_idx_t             nibble,
    input  logic                 slot_last,
    input  csr_op_e              op,
    input  csr_addr_t            csr_addr,
    input  nib_t                 wdata,
    input  nib_t                 pc,
    input  logic [4:0]           irq_cause,
    output logic                 mstatus_mie,
    output nib_t                 mstatus_nib,
    output logic                 double_fault,
    output nib_t                 mcause_nib,
    output nib_t                 mepc_nib,
    output logic                 redirect,
    output logic [MEPC_BITS-1:0] redirect_addr
);

    localparam int MEPC_NIBS = MEPC_BITS / 4;

    logic                 is_trap;
    logic                 is_entry;
    logic                 is_mret;
    logic                 mstatus_mte;   // Non-standard trap enable
    logic                 mstatus_mpie;
    logic                 df_now;
    logic                 df_q;
    logic [4:0]           trap_code;
    logic [5:0]           mcause;        // Bit 5 maps to mcause[31]
    logic [MEPC_BITS-1:0] mepc;
    nib_t                 mst_new;
    nib_t                 mepc_new;
    nib_t                 mepc_in;

    assign is_trap  = op inside {op_ecall, op_ebreak, op_illegal};
    assign is_entry = is_trap || (op == op_irq);
    assign is_mret  = (op == op_mret);

    // mte drops at nibble 0 of a trap so the decision is held for the slot
    assign df_now       = (nibble == 3'd0) && is_trap && !mstatus_mte;
    assign double_fault = (nibble == 3'd0) ? df_now : df_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            df_q <= 1'b0;
        end else if (nibble == 3'd0) begin
            df_q <= df_now;
        end
    end

    // Trap enable, set again by mret or double-fault recovery
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mstatus_mte <= 1'b1;
        end else if (double_fault) begin
            mstatus_mte <= 1'b1;
        end else if (nibble == 3'd0 && is_entry) begin
            mstatus_mte <= 1'b0;
        end else if (nibble == 3'd0 && is_mret) begin
            mstatus_mte <= 1'b1;
        end
    end

    assign mstatus_nib = (nibble == 3'd0) ? {mstatus_mie, mstatus_mte, 2'b00} :
                         (nibble == 3'd1) ? {mstatus_mpie, 3'b000} : 4'b0000;
    assign mst_new     = csr_apply(op, mstatus_nib, wdata);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mstatus_mie  <= 1'b1;
            mstatus_mpie <= 1'b0;
        end else if (double_fault) begin
            mstatus_mie  <= 1'b1;
            mstatus_mpie <= 1'b0;
        end else if (nibble == 3'd0 && is_entry) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (nibble == 3'd0 && is_mret) begin
            mstatus_mie  <= mstatus_mpie;
        end else if (csr_addr == CSR_MSTATUS) begin
            if (nibble == 3'd0) mstatus_mie <= mst_new[3];        // Bit 3
            else if (nibble == 3'd1) mstatus_mpie <= mst_new[3];  // Bit 7
        end
    end

    always_comb begin
        case (op)
            op_ecall:  trap_code = CAUSE_ECALL;
            op_ebreak: trap_code = CAUSE_EBREAK;
            default:   trap_code = CAUSE_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mcause <= '0;
        end else if (nibble == 3'd0 && is_entry) begin
            mcause <= (op == op_irq) ? {1'b1, irq_cause} : {1'b0, trap_code};
        end
    end

    assign mcause_nib = (nibble == 3'd0) ? mcause[3:0] :
                        (nibble == 3'd1) ? {3'b000, mcause[4]} :
                        (nibble == 3'd7) ? {mcause[5], 3'b000} : 4'b0000;

    // mepc rotates on the low nibbles only and is aligned again by nibble 7
    assign mepc_new = csr_apply(op, mepc[3:0], wdata);
    assign mepc_in  = is_entry                 ? pc :
                      (csr_addr == CSR_MEPC)   ? mepc_new : mepc[3:0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mepc <= '0;
        end else if (nibble < MEPC_NIBS) begin
            mepc <= {mepc_in, mepc[MEPC_BITS-1:4]};
        end
    end

    assign mepc_nib = (nibble < MEPC_NIBS) ? mepc[3:0] : 4'b0000;

    assign redirect = slot_last && (is_entry || is_mret);

    always_comb begin
        if (is_mret)            redirect_addr = mepc;
        else if (op == op_irq)  redirect_addr = VEC_IRQ[MEPC_BITS-1:0];
        else if (double_fault)  redirect_addr = VEC_RESET[MEPC_BITS-1:0];
        else                    redirect_addr = VEC_TRAP[MEPC_BITS-1:0];
    end

    assert property (@(posedge clk) disable iff (!rstn) redirect |-> (nibble == 3'd7))
        else $error("redirect outside the last nibble of a slot");

endmodule

//--- sources.f
hw/qv_csr_pkg.sv
hw/csr_timebase.sv
hw/trap_status.sv
hw/irq_controller.sv
hw/csr_read_mux.sv
hw/machine_csr_unit.sv
dv/machine_csr_unit_tb.sv
